//--- hdl/atop_filter_pkg.sv
// AXI widths are fixed here (ID 4, address 32, data 32, len 8); no user or sideband fields exist
package atop_filter_pkg;

  // Bus widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [IdWidth-1:0]     id_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;
  typedef logic [7:0]             len_t;
  typedef logic [5:0]             atop_t;

  // Upper two bits of aw.atop select the atomic class
  typedef enum logic [1:0] {
    ATOP_NONE     = 2'b00,
    ATOP_STORE    = 2'b01,
    ATOP_LOAD     = 2'b10,
    ATOP_SWAP_CMP = 2'b11
  } atop_class_e;

  // Only the two codes the filter produces or forwards
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    atop_t atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

  // Master to slave direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Slave to master direction
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_rsp_t;

  // Pending R injection for a non-store atomic
  typedef struct packed {
    id_t  id;
    len_t len;
  } resp_cmd_t;

  typedef enum logic [2:0] {
    W_FEEDTHROUGH, BLOCK_AW, ABSORB_W, HOLD_B, INJECT_B, WAIT_R
  } w_state_e;

  typedef enum logic [1:0] {
    R_FEEDTHROUGH, INJECT_R, R_HOLD
  } r_state_e;

endpackage

//--- hdl/write_burst_counter.sv
// MaxWriteTxns must be at least 1; at most one complete W burst may run ahead of its AW
`timescale 1ns/1ps

module write_burst_counter #(
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic aw_sent_i,
  input  logic w_last_sent_i,
  output logic aw_room_o,
  output logic w_missing_o,
  output logic w_ahead_o
);

  // Two bits minimum so that -1 can be told apart from +1
  localparam int unsigned CntWidth = (MaxWriteTxns == 1) ? 2 : $clog2(MaxWriteTxns + 1);

  typedef struct packed {
    logic                underflow;
    logic [CntWidth-1:0] cnt;
  } cnt_t;

  cnt_t cnt_d, cnt_q;

  // AW downstream still waits for W data
  assign w_missing_o = !cnt_q.underflow && (cnt_q.cnt != '0);
  // Counter at -1, one W burst is ahead
  assign w_ahead_o   = cnt_q.underflow && (&cnt_q.cnt);
  // Room when below the cap or when the next AW only pairs up with the early W
  assign aw_room_o   = w_ahead_o || (cnt_q.cnt < MaxWriteTxns);

  always_comb begin
    cnt_d = cnt_q;
    if (aw_sent_i) begin
      cnt_d.cnt = cnt_d.cnt + 1'b1;
    end
    if (w_last_sent_i) begin
      cnt_d.cnt = cnt_d.cnt - 1'b1;
    end
    // Leave underflow once back at zero, enter it on a wrap from zero
    if (cnt_q.underflow && (cnt_d.cnt == '0)) begin
      cnt_d.underflow = 1'b0;
    end else if ((cnt_q.cnt == '0) && (&cnt_d.cnt)) begin
      cnt_d.underflow = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // FSM gating keeps the outstanding count within the cap
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !cnt_q.underflow |-> (cnt_q.cnt <= MaxWriteTxns));

  // FSM only sends an AW downstream when this counter reports room
  assert property (@(posedge clk_i) disable iff (!rst_ni) aw_sent_i |-> aw_room_o);

endmodule

//--- hdl/write_filter_fsm.sv
// Atomic bursts must use an ID that no other in-flight burst shares; one atomic is handled at a time
`timescale 1ns/1ps

module write_filter_fsm
  import atop_filter_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Upstream write request
  input  aw_chan_t  slv_aw_i,
  input  logic      slv_aw_valid_i,
  input  w_chan_t   slv_w_i,
  input  logic      slv_w_valid_i,
  input  logic      slv_b_ready_i,
  // Upstream write response
  output logic      slv_aw_ready_o,
  output logic      slv_w_ready_o,
  output b_chan_t   slv_b_o,
  output logic      slv_b_valid_o,
  // Downstream write request
  output aw_chan_t  mst_aw_o,
  output logic      mst_aw_valid_o,
  output w_chan_t   mst_w_o,
  output logic      mst_w_valid_o,
  output logic      mst_b_ready_o,
  // Downstream write response
  input  logic      mst_aw_ready_i,
  input  logic      mst_w_ready_i,
  input  b_chan_t   mst_b_i,
  input  logic      mst_b_valid_i,
  // Burst counter
  output logic      aw_sent_o,
  output logic      w_last_sent_o,
  input  logic      aw_room_i,
  input  logic      w_missing_i,
  input  logic      w_ahead_i,
  // R command register
  output logic      cmd_push_o,
  output resp_cmd_t cmd_o,
  input  logic      cmd_valid_i
);

  w_state_e    state_d, state_q;
  id_t         id_d, id_q;
  atop_class_e aw_class;
  w_state_e    after_last_w;

  assign aw_class = atop_class_e'(slv_aw_i.atop[5:4]);

  // Where to go once the absorbed W burst ends
  // A forwarded B stuck under back-pressure goes first
  assign after_last_w = (mst_b_valid_i && !slv_b_ready_i) ? HOLD_B : INJECT_B;

  // Payload goes downstream unchanged except atop
  always_comb begin
    mst_aw_o      = slv_aw_i;
    mst_aw_o.atop = '0;
  end
  assign mst_w_o = slv_w_i;

  // R command carries the atomic's ID and burst length
  assign cmd_o.id  = slv_aw_i.id;
  assign cmd_o.len = slv_aw_i.len;

  // Handshake pulses for the burst counter
  assign aw_sent_o     = mst_aw_valid_o && mst_aw_ready_i;
  assign w_last_sent_o = mst_w_valid_o && mst_w_ready_i && slv_w_i.last;

  always_comb begin
    // AW and W closed by default
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    mst_w_valid_o  = 1'b0;
    slv_w_ready_o  = 1'b0;
    // B passes through by default
    mst_b_ready_o  = slv_b_ready_i;
    slv_b_o        = mst_b_i;
    slv_b_valid_o  = mst_b_valid_i;
    cmd_push_o     = 1'b0;
    id_d           = id_q;
    state_d        = state_q;

    unique case (state_q)
      W_FEEDTHROUGH: begin
        // AW only while the outstanding cap allows
        if (aw_room_i) begin
          mst_aw_valid_o = slv_aw_valid_i;
          slv_aw_ready_o = mst_aw_ready_i;
        end
        // W for a pending downstream AW, or alongside a plain AW
        // but never a second burst ahead of its AW
        if (w_missing_i ||
            (slv_aw_valid_i && (aw_class == ATOP_NONE) && !w_ahead_i)) begin
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end
        // Atomic AW is swallowed here
        if (slv_aw_valid_i && (aw_class != ATOP_NONE)) begin
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b1;
          id_d           = slv_aw_i.id;
          // Stores need no R response
          cmd_push_o     = (aw_class != ATOP_STORE);
          if (w_missing_i) begin
            // Earlier W bursts must drain first
            state_d = BLOCK_AW;
          end else begin
            mst_w_valid_o = 1'b0;
            slv_w_ready_o = 1'b1;
            if (slv_w_valid_i && slv_w_i.last) begin
              state_d = after_last_w;
            end else begin
              state_d = ABSORB_W;
            end
          end
        end
      end

      BLOCK_AW: begin
        if (w_missing_i) begin
          // Let outstanding plain bursts finish
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end else begin
          // Next W burst belongs to the atomic
          slv_w_ready_o = 1'b1;
          if (slv_w_valid_i && slv_w_i.last) begin
            state_d = after_last_w;
          end else begin
            state_d = ABSORB_W;
          end
        end
      end

      ABSORB_W: begin
        // Drop every beat of the atomic's W burst
        slv_w_ready_o = 1'b1;
        if (slv_w_valid_i && slv_w_i.last) begin
          state_d = after_last_w;
        end
      end

      HOLD_B: begin
        // Wait for the stalled forwarded B to go out
        if (mst_b_valid_i && slv_b_ready_i) begin
          state_d = INJECT_B;
        end
      end

      INJECT_B: begin
        // Foreign B responses wait meanwhile
        mst_b_ready_o = 1'b0;
        slv_b_o.id    = id_q;
        slv_b_o.resp  = RESP_SLVERR;
        slv_b_valid_o = 1'b1;
        if (slv_b_ready_i) begin
          // R injection may still be running
          state_d = cmd_valid_i ? WAIT_R : W_FEEDTHROUGH;
        end
      end

      WAIT_R: begin
        if (!cmd_valid_i) begin
          state_d = W_FEEDTHROUGH;
        end
      end

      default: state_d = W_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= W_FEEDTHROUGH;
    end else begin
      state_q <= state_d;
    end
  end

  // Stored atomic ID, only read in INJECT_B
  always_ff @(posedge clk_i) begin
    id_q <= id_d;
  end

  // Command register must be drained before the next atomic is taken
  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_push_o |-> !cmd_valid_i);

endmodule

//--- hdl/resp_cmd_register.sv
// Single entry only; the producer must wait for it to empty before pushing again
`timescale 1ns/1ps

module resp_cmd_register
  import atop_filter_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  resp_cmd_t cmd_i,
  output logic      cmd_valid_o,
  output resp_cmd_t cmd_o,
  input  logic      pop_i
);

  logic      full_q;
  resp_cmd_t cmd_q;

  // Full flag, push wins over pop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (push_i) begin
      full_q <= 1'b1;
    end else if (pop_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload captured on push
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      cmd_q <= cmd_i;
    end
  end

  assign cmd_valid_o = full_q;
  assign cmd_o       = cmd_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_q);
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> full_q);

endmodule

//--- hdl/read_resp_injector.sv
// Injection waits for any forwarded R burst to finish; injected beats carry zero data
`timescale 1ns/1ps

module read_resp_injector
  import atop_filter_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Upstream R ready
  input  logic      slv_r_ready_i,
  // Downstream R channel
  input  r_chan_t   mst_r_i,
  input  logic      mst_r_valid_i,
  output logic      mst_r_ready_o,
  // Upstream R channel
  output r_chan_t   slv_r_o,
  output logic      slv_r_valid_o,
  // Command register
  input  logic      cmd_valid_i,
  input  resp_cmd_t cmd_i,
  output logic      pop_o
);

  r_state_e state_d, state_q;
  len_t     beats_d, beats_q;

  always_comb begin
    // Forward by default
    slv_r_o       = mst_r_i;
    slv_r_valid_o = mst_r_valid_i;
    mst_r_ready_o = slv_r_ready_i;
    pop_o         = 1'b0;
    beats_d       = beats_q;
    state_d       = state_q;

    unique case (state_q)
      R_FEEDTHROUGH: begin
        // Stalled beat or open forwarded burst blocks injection
        if (mst_r_valid_i && !(slv_r_ready_i && mst_r_i.last)) begin
          state_d = R_HOLD;
        end else if (cmd_valid_i) begin
          beats_d = cmd_i.len;
          state_d = INJECT_R;
        end
      end

      INJECT_R: begin
        // Downstream R waits while the error burst runs
        mst_r_ready_o = 1'b0;
        slv_r_o       = '0;
        slv_r_o.id    = cmd_i.id;
        slv_r_o.resp  = RESP_SLVERR;
        slv_r_o.last  = (beats_q == '0);
        slv_r_valid_o = 1'b1;
        if (slv_r_ready_i) begin
          if (beats_q == '0) begin
            // Final beat consumes the command
            pop_o   = 1'b1;
            state_d = R_FEEDTHROUGH;
          end else begin
            beats_d = beats_q - 1'b1;
          end
        end
      end

      R_HOLD: begin
        // Leave once the forwarded burst's last beat transfers
        if (mst_r_valid_i && slv_r_ready_i && mst_r_i.last) begin
          state_d = R_FEEDTHROUGH;
        end
      end

      default: state_d = R_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= R_FEEDTHROUGH;
    end else begin
      state_q <= state_d;
    end
  end

  // Remaining beats, loaded before INJECT_R
  always_ff @(posedge clk_i) begin
    beats_q <= beats_d;
  end

  // Injected beat stays put while upstream stalls
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == INJECT_R) && !slv_r_ready_i |=> slv_r_valid_o && $stable(slv_r_o));

endmodule

//--- hdl/atop_filter_top.sv
// Place between an ATOP-capable master and a slave without ATOP support; AR is not filtered
`timescale 1ns/1ps

module atop_filter_top
  import atop_filter_pkg::*;
#(
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  axi_req_t slv_req_i,
  output axi_rsp_t slv_rsp_o,
  output axi_req_t mst_req_o,
  input  axi_rsp_t mst_rsp_i
);

  // Write side outputs
  aw_chan_t  mst_aw;
  w_chan_t   mst_w;
  b_chan_t   slv_b;
  logic      mst_aw_valid, mst_w_valid, mst_b_ready;
  logic      slv_aw_ready, slv_w_ready, slv_b_valid;
  // Read side outputs
  r_chan_t   slv_r;
  logic      slv_r_valid, mst_r_ready;
  // Counter flags and pulses
  logic      aw_sent, w_last_sent, aw_room, w_missing, w_ahead;
  // Command path
  logic      cmd_push, cmd_pop, cmd_valid;
  resp_cmd_t cmd_in, cmd_out;

  write_burst_counter #(
    .MaxWriteTxns(MaxWriteTxns)
  ) i_write_burst_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .aw_sent_i    (aw_sent),
    .w_last_sent_i(w_last_sent),
    .aw_room_o    (aw_room),
    .w_missing_o  (w_missing),
    .w_ahead_o    (w_ahead)
  );

  write_filter_fsm i_write_filter_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_aw_i      (slv_req_i.aw),
    .slv_aw_valid_i(slv_req_i.aw_valid),
    .slv_w_i       (slv_req_i.w),
    .slv_w_valid_i (slv_req_i.w_valid),
    .slv_b_ready_i (slv_req_i.b_ready),
    .slv_aw_ready_o(slv_aw_ready),
    .slv_w_ready_o (slv_w_ready),
    .slv_b_o       (slv_b),
    .slv_b_valid_o (slv_b_valid),
    .mst_aw_o      (mst_aw),
    .mst_aw_valid_o(mst_aw_valid),
    .mst_w_o       (mst_w),
    .mst_w_valid_o (mst_w_valid),
    .mst_b_ready_o (mst_b_ready),
    .mst_aw_ready_i(mst_rsp_i.aw_ready),
    .mst_w_ready_i (mst_rsp_i.w_ready),
    .mst_b_i       (mst_rsp_i.b),
    .mst_b_valid_i (mst_rsp_i.b_valid),
    .aw_sent_o     (aw_sent),
    .w_last_sent_o (w_last_sent),
    .aw_room_i     (aw_room),
    .w_missing_i   (w_missing),
    .w_ahead_i     (w_ahead),
    .cmd_push_o    (cmd_push),
    .cmd_o         (cmd_in),
    .cmd_valid_i   (cmd_valid)
  );

  resp_cmd_register i_resp_cmd_register (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (cmd_push),
    .cmd_i      (cmd_in),
    .cmd_valid_o(cmd_valid),
    .cmd_o      (cmd_out),
    .pop_i      (cmd_pop)
  );

  read_resp_injector i_read_resp_injector (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .slv_r_ready_i(slv_req_i.r_ready),
    .mst_r_i      (mst_rsp_i.r),
    .mst_r_valid_i(mst_rsp_i.r_valid),
    .mst_r_ready_o(mst_r_ready),
    .slv_r_o      (slv_r),
    .slv_r_valid_o(slv_r_valid),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd_out),
    .pop_o        (cmd_pop)
  );

  // Downstream request, AR straight through
  always_comb begin
    mst_req_o.aw       = mst_aw;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w        = mst_w;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = mst_b_ready;
    mst_req_o.ar       = slv_req_i.ar;
    mst_req_o.ar_valid = slv_req_i.ar_valid;
    mst_req_o.r_ready  = mst_r_ready;
  end

  // Upstream response
  always_comb begin
    slv_rsp_o.aw_ready = slv_aw_ready;
    slv_rsp_o.w_ready  = slv_w_ready;
    slv_rsp_o.b        = slv_b;
    slv_rsp_o.b_valid  = slv_b_valid;
    slv_rsp_o.ar_ready = mst_rsp_i.ar_ready;
    slv_rsp_o.r        = slv_r;
    slv_rsp_o.r_valid  = slv_r_valid;
  end

endmodule

//--- sim/tb_vectors.svh
// Included inside the testbench after the package import; entries run strictly one at a time
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Upstream transaction type
typedef enum logic [1:0] {
  KIND_WRITE,
  KIND_ATOMIC,
  KIND_READ
} kind_e;

// One table entry with its expected responses
typedef struct packed {
  kind_e      kind;
  id_t        id;
  addr_t      addr;
  len_t       len;
  atop_t      atop;
  data_t      seed;
  resp_e      exp_b;
  logic [8:0] exp_r_beats;
  resp_e      exp_r;
  logic       exp_down;
} vec_t;

localparam int unsigned NumVecs = 12;

// kind, id, addr, len, atop, W data seed, B resp, R beats, R resp, reaches downstream
// Reads carry no B, so their B resp column is unused
// Plain writes may carry stray low atop bits that must not leak downstream
localparam vec_t Vectors [NumVecs] = '{
  '{KIND_WRITE,  4'h1, 32'h1000, 8'd0, 6'h00, 32'h1100, RESP_OKAY,   9'd0, RESP_OKAY,   1'b1},
  '{KIND_READ,   4'h2, 32'h2000, 8'd3, 6'h00, 32'h0000, RESP_OKAY,   9'd4, RESP_OKAY,   1'b1},
  '{KIND_ATOMIC, 4'h3, 32'h3000, 8'd1, 6'h10, 32'h3300, RESP_SLVERR, 9'd0, RESP_OKAY,   1'b0},
  '{KIND_WRITE,  4'h4, 32'h4000, 8'd3, 6'h0c, 32'h4400, RESP_OKAY,   9'd0, RESP_OKAY,   1'b1},
  '{KIND_ATOMIC, 4'h5, 32'h5000, 8'd2, 6'h20, 32'h5500, RESP_SLVERR, 9'd3, RESP_SLVERR, 1'b0},
  '{KIND_READ,   4'h6, 32'h6000, 8'd0, 6'h00, 32'h0000, RESP_OKAY,   9'd1, RESP_OKAY,   1'b1},
  '{KIND_ATOMIC, 4'h7, 32'h7000, 8'd0, 6'h30, 32'h7700, RESP_SLVERR, 9'd1, RESP_SLVERR, 1'b0},
  '{KIND_WRITE,  4'h8, 32'h8000, 8'd7, 6'h00, 32'h8800, RESP_OKAY,   9'd0, RESP_OKAY,   1'b1},
  '{KIND_ATOMIC, 4'h9, 32'h9000, 8'd1, 6'h31, 32'h9900, RESP_SLVERR, 9'd2, RESP_SLVERR, 1'b0},
  '{KIND_READ,   4'ha, 32'ha000, 8'd7, 6'h00, 32'h0000, RESP_OKAY,   9'd8, RESP_OKAY,   1'b1},
  '{KIND_ATOMIC, 4'hb, 32'hb000, 8'd0, 6'h1a, 32'hbb00, RESP_SLVERR, 9'd0, RESP_OKAY,   1'b0},
  '{KIND_WRITE,  4'hc, 32'hc000, 8'd1, 6'h03, 32'hcc00, RESP_OKAY,   9'd0, RESP_OKAY,   1'b1}
};

`endif

//--- sim/tb_atop_filter.sv
// One entry in flight at a time; the slave model is always ready on AW, W and AR
`timescale 1ns/1ps

module tb_atop_filter
  import atop_filter_pkg::*;
();

  `include "tb_vectors.svh"

  localparam time ClkPeriod = 40ns;

  logic        clk_i;
  logic        rst_ni;
  axi_req_t    slv_drv, slv_req, mst_req;
  axi_rsp_t    slv_rsp, mst_rsp;
  logic        b_ready_bp, r_ready_bp;
  logic [31:0] lfsr;
  vec_t        cur;
  int unsigned vec_idx;
  // Handshakes seen during the current entry
  int unsigned aw_fires, w_fires, b_fires, ar_fires, r_fires, down_fires, down_w_fires;
  // Slave model state
  id_t         slave_aw_ids[$];
  id_t         slave_b_ids[$];
  ar_chan_t    slave_ars[$];
  int unsigned slave_w_lasts, slave_r_beat;

  atop_filter_top #(
    .MaxWriteTxns(4)
  ) UUT (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .slv_req_i(slv_req),
    .slv_rsp_o(slv_rsp),
    .mst_req_o(mst_req),
    .mst_rsp_i(mst_rsp)
  );

  // Upstream ready lines come from the LFSR
  always_comb begin
    slv_req         = slv_drv;
    slv_req.b_ready = b_ready_bp;
    slv_req.r_ready = r_ready_bp;
  end

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic string entry_name(input string what);
    return $sformatf("vec%0d %s", vec_idx, what);
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "check failed");
    end
  endtask

  function automatic bit entry_done(input int unsigned beats);
    if (cur.kind == KIND_READ) begin
      return r_fires == cur.exp_r_beats;
    end
    return (aw_fires == 1) && (w_fires == beats) && (b_fires == 1) &&
           (r_fires == cur.exp_r_beats);
  endfunction

  // Monitor samples on the rising edge after inputs settled at the falling edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (slv_req.aw_valid && slv_rsp.aw_ready) aw_fires++;
      if (slv_req.w_valid && slv_rsp.w_ready) w_fires++;
      if (slv_req.ar_valid && slv_rsp.ar_ready) ar_fires++;
      if (slv_rsp.b_valid && slv_req.b_ready) begin
        check_eq(entry_name("B id"), cur.id, slv_rsp.b.id);
        check_eq(entry_name("B resp"), cur.exp_b, slv_rsp.b.resp);
        b_fires++;
      end
      if (slv_rsp.r_valid && slv_req.r_ready) begin
        check_eq(entry_name("R beat in range"), 1'b1, r_fires < cur.exp_r_beats);
        check_eq(entry_name("R id"), cur.id, slv_rsp.r.id);
        check_eq(entry_name("R resp"), cur.exp_r, slv_rsp.r.resp);
        check_eq(entry_name("R last"), (r_fires + 1) == cur.exp_r_beats, slv_rsp.r.last);
        if (cur.kind == KIND_READ) begin
          check_eq(entry_name("R data"), cur.addr + r_fires, slv_rsp.r.data);
        end
        r_fires++;
      end
      // Downstream side as seen by the slave model
      if (mst_req.aw_valid && mst_rsp.aw_ready) begin
        check_eq(entry_name("down AW atop"), 6'h00, mst_req.aw.atop);
        check_eq(entry_name("down AW id"), cur.id, mst_req.aw.id);
        check_eq(entry_name("down AW addr"), cur.addr, mst_req.aw.addr);
        check_eq(entry_name("down AW len"), cur.len, mst_req.aw.len);
        slave_aw_ids.push_back(mst_req.aw.id);
        down_fires++;
      end
      if (mst_req.w_valid && mst_rsp.w_ready) begin
        check_eq(entry_name("down W data"), cur.seed + down_w_fires, mst_req.w.data);
        check_eq(entry_name("down W strb"), 4'hf, mst_req.w.strb);
        check_eq(entry_name("down W last"), down_w_fires == cur.len, mst_req.w.last);
        down_w_fires++;
        if (mst_req.w.last) slave_w_lasts++;
      end
      if (mst_req.ar_valid && mst_rsp.ar_ready) begin
        check_eq(entry_name("down AR addr"), cur.addr, mst_req.ar.addr);
        slave_ars.push_back(mst_req.ar);
        down_fires++;
      end
      if (mst_rsp.b_valid && mst_req.b_ready) void'(slave_b_ids.pop_front());
      if (mst_rsp.r_valid && mst_req.r_ready) begin
        if (mst_rsp.r.last) begin
          void'(slave_ars.pop_front());
          slave_r_beat = 0;
        end else begin
          slave_r_beat++;
        end
      end
      // B once an AW has its complete W burst
      if ((slave_aw_ids.size() != 0) && (slave_w_lasts != 0)) begin
        slave_b_ids.push_back(slave_aw_ids.pop_front());
        slave_w_lasts--;
      end
    end
  end

  // Slave model outputs and back-pressure change on the falling edge
  initial begin
    mst_rsp          = '0;
    mst_rsp.aw_ready = 1'b1;
    mst_rsp.w_ready  = 1'b1;
    mst_rsp.ar_ready = 1'b1;
    mst_rsp.b.resp   = RESP_OKAY;
    mst_rsp.r.resp   = RESP_OKAY;
    b_ready_bp       = 1'b0;
    r_ready_bp       = 1'b0;
    lfsr             = 32'hea7d_dfd8;
    slave_w_lasts    = 0;
    slave_r_beat     = 0;
    forever begin
      @(negedge clk_i);
      lfsr       = lfsr_step(lfsr);
      b_ready_bp = lfsr[0];
      lfsr       = lfsr_step(lfsr);
      r_ready_bp = lfsr[0];
      mst_rsp.b_valid = (slave_b_ids.size() != 0);
      if (mst_rsp.b_valid) mst_rsp.b.id = slave_b_ids[0];
      mst_rsp.r_valid = (slave_ars.size() != 0);
      if (mst_rsp.r_valid) begin
        mst_rsp.r.id   = slave_ars[0].id;
        mst_rsp.r.data = slave_ars[0].addr + slave_r_beat;
        mst_rsp.r.last = (slave_r_beat == slave_ars[0].len);
      end
    end
  end

  task automatic run_vector(input int unsigned idx);
    int unsigned beats;
    @(negedge clk_i);
    vec_idx      = idx;
    cur          = Vectors[idx];
    beats        = cur.len + 1;
    aw_fires     = 0;
    w_fires      = 0;
    b_fires      = 0;
    ar_fires     = 0;
    r_fires      = 0;
    down_fires   = 0;
    down_w_fires = 0;
    if (cur.kind == KIND_READ) begin
      slv_drv.ar.id    = cur.id;
      slv_drv.ar.addr  = cur.addr;
      slv_drv.ar.len   = cur.len;
      slv_drv.ar_valid = 1'b1;
    end else begin
      slv_drv.aw.id    = cur.id;
      slv_drv.aw.addr  = cur.addr;
      slv_drv.aw.len   = cur.len;
      slv_drv.aw.atop  = cur.atop;
      slv_drv.aw_valid = 1'b1;
      slv_drv.w_valid  = 1'b1;
    end
    slv_drv.w.data = cur.seed;
    slv_drv.w.strb = '1;
    slv_drv.w.last = (cur.len == 0);
    // Advance AW, AR and W from the handshakes of the last rising edge
    do begin
      @(negedge clk_i);
      if (aw_fires != 0) slv_drv.aw_valid = 1'b0;
      if (ar_fires != 0) slv_drv.ar_valid = 1'b0;
      if (w_fires >= beats) slv_drv.w_valid = 1'b0;
      slv_drv.w.data = cur.seed + w_fires;
      slv_drv.w.last = (w_fires == cur.len);
    end while (!entry_done(beats));
    check_eq(entry_name("downstream count"), cur.exp_down, down_fires);
    check_eq(entry_name("downstream W beats"),
             (cur.exp_down && (cur.kind == KIND_WRITE)) ? beats : 0, down_w_fires);
    check_eq(entry_name("B count"), cur.kind != KIND_READ, b_fires);
  endtask

  initial begin
    slv_drv = '0;
    rst_ni  = 1'b0;
    vec_idx = 0;
    cur     = Vectors[0];
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < NumVecs; i++) begin
      run_vector(i);
    end
    $display("** PASS **");
    $finish;
  end

  // Budget per entry grows with the longest burst in the table
  initial begin
    int unsigned max_len;
    max_len = 0;
    for (int i = 0; i < NumVecs; i++) begin
      if (Vectors[i].len > max_len) max_len = Vectors[i].len;
    end
    #((NumVecs * (max_len + 20) + 5) * ClkPeriod);
    $display("Timeout: the vector table did not complete within the time limit");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- atop_filter.f
+incdir+sim
hdl/atop_filter_pkg.sv
hdl/write_burst_counter.sv
hdl/write_filter_fsm.sv
hdl/resp_cmd_register.sv
hdl/read_resp_injector.sv
hdl/atop_filter_top.sv
sim/tb_atop_filter.sv

//--- Bender.yml
package:
  name: atop_filter

sources:
  - files:
      - hdl/atop_filter_pkg.sv
      - hdl/write_burst_counter.sv
      - hdl/write_filter_fsm.sv
      - hdl/resp_cmd_register.sv
      - hdl/read_resp_injector.sv
      - hdl/atop_filter_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_atop_filter.sv
